//--- rtl/core_req_port.sv
`include "icache_config.svh"

module core_req_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      core_req,
    input  logic [`ICACHE_ADDR_W-1:0] core_addr,
    input  logic                      resp_valid,
    input  logic [`ICACHE_WORD_W-1:0] resp_data,
    output logic                      core_ack,
    output logic [`ICACHE_WORD_W-1:0] core_data,
    output logic                      lookup_valid,
    output logic [`ICACHE_ADDR_W-1:0] lookup_addr
);

    icache_pkg::core_port_state_t state;

    logic new_req;
    logic resp_taken;

    // only a request seen in IDLE is a new one
    assign new_req = (state == icache_pkg::IDLE) && core_req;
    assign resp_taken = (state == icache_pkg::LOOKUP) && resp_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::IDLE;
            lookup_valid <= 1'b0;
            core_ack <= 1'b0;
        end else begin
            lookup_valid <= 1'b0;
            case (state)
                icache_pkg::IDLE: begin
                    if (core_req) begin
                        lookup_valid <= 1'b1;
                        state <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    // hit or refill, both end with resp_valid
                    if (resp_valid) begin
                        core_ack <= 1'b1;
                        state <= icache_pkg::ACK;
                    end
                end
                icache_pkg::ACK: begin
                    // release phase, hold ack until the core lets go
                    if (!core_req) begin
                        core_ack <= 1'b0;
                        state <= icache_pkg::IDLE;
                    end
                end
                default: begin
                    core_ack <= 1'b0;
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // address captured once per request
    always_ff @(posedge clk) begin
        if (new_req) begin
            lookup_addr <= core_addr;
        end
    end

    // word held stable for the whole ack phase
    always_ff @(posedge clk) begin
        if (resp_taken) begin
            core_data <= resp_data;
        end
    end

endmodule

//--- rtl/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// core side byte address and instruction word
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// memory beat and the full cache line
`define ICACHE_BEAT_W 128
`define ICACHE_LINE_W 512
`define ICACHE_BEATS_PER_LINE 4

// address split, 64-byte line of 16-byte blocks of 4-byte words
`define ICACHE_TAG_LSB 6
`define ICACHE_BEAT_LSB 4
`define ICACHE_WORD_LSB 2

`endif

//--- rtl/icache_line_store.sv
`include "icache_config.svh"

module icache_line_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      lookup_valid,
    input  logic [`ICACHE_ADDR_W-1:0] lookup_addr,
    input  logic                      beat_valid,
    input  mem_bus_pkg::beat_idx_t    beat_idx,
    input  logic [`ICACHE_BEAT_W-1:0] beat_data,
    output logic                      resp_valid,
    output logic [`ICACHE_WORD_W-1:0] resp_data,
    output logic                      fill_start,
    output mem_bus_pkg::block_addr_t  fill_block
);

    icache_pkg::cache_state_t state;

    // the single line
    logic [`ICACHE_LINE_W-1:0] line_data;
    logic [`ICACHE_LINE_W-1:0] line_next;
    icache_pkg::tag_t          line_tag;
    logic                      line_valid;

    // request that missed, replayed after the refill
    logic [`ICACHE_ADDR_W-1:0] pending_addr;

    icache_pkg::tag_t lookup_tag;
    logic             hit;
    logic             new_lookup;
    logic             fill_beat;
    logic             last_beat;

    function automatic logic [`ICACHE_WORD_W-1:0] select_word(
        input logic [`ICACHE_LINE_W-1:0] line,
        input logic [`ICACHE_ADDR_W-1:0] addr
    );
        logic [`ICACHE_TAG_LSB-`ICACHE_WORD_LSB-1:0] word_idx;
        word_idx = addr[`ICACHE_TAG_LSB-1:`ICACHE_WORD_LSB];
        return line[word_idx*`ICACHE_WORD_W +: `ICACHE_WORD_W];
    endfunction

    assign lookup_tag = lookup_addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    assign hit = line_valid && (line_tag == lookup_tag);
    assign new_lookup = (state == icache_pkg::READY) && lookup_valid;
    assign fill_beat = (state == icache_pkg::MISS) && beat_valid;
    assign last_beat = fill_beat
        && (beat_idx == mem_bus_pkg::beat_idx_t'(`ICACHE_BEATS_PER_LINE-1));

    // line with the incoming beat already in its slot,
    // so the replay can read beat 3 in the same cycle it lands
    always_comb begin
        line_next = line_data;
        if (beat_valid) begin
            line_next[beat_idx*`ICACHE_BEAT_W +: `ICACHE_BEAT_W] = beat_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::RST;
            line_valid <= 1'b0;
            resp_valid <= 1'b0;
            fill_start <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            fill_start <= 1'b0;
            case (state)
                icache_pkg::RST: begin
                    state <= icache_pkg::READY;
                end
                icache_pkg::READY: begin
                    if (lookup_valid && hit) begin
                        resp_valid <= 1'b1;
                    end else if (lookup_valid) begin
                        fill_start <= 1'b1;
                        line_valid <= 1'b0;
                        state <= icache_pkg::MISS;
                    end
                end
                icache_pkg::MISS: begin
                    // line complete, answer the pending request
                    if (last_beat) begin
                        line_valid <= 1'b1;
                        resp_valid <= 1'b1;
                        state <= icache_pkg::READY;
                    end
                end
                default: begin
                    state <= icache_pkg::RST;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (new_lookup && hit) begin
            resp_data <= select_word(line_data, lookup_addr);
        end else if (new_lookup) begin
            pending_addr <= lookup_addr;
            // refill starts at the first block of the line
            fill_block <= {lookup_tag, {(`ICACHE_TAG_LSB-`ICACHE_BEAT_LSB){1'b0}}};
        end
        if (fill_beat) begin
            line_data <= line_next;
        end
        if (last_beat) begin
            line_tag <= pending_addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
            resp_data <= select_word(line_next, pending_addr);
        end
    end

endmodule

//--- rtl/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    // line store control
    typedef enum logic [1:0] {
        RST,
        READY,
        MISS
    } cache_state_t;

    // four-phase slave facing the core
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        ACK
    } core_port_state_t;

    // upper address bits naming one 64-byte line
    typedef logic [`ICACHE_ADDR_W-`ICACHE_TAG_LSB-1:0] tag_t;

endpackage

//--- rtl/icache_top.sv
`include "icache_config.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    // core side
    input  logic                      core_req,
    input  logic [`ICACHE_ADDR_W-1:0] core_addr,
    output logic                      core_ack,
    output logic [`ICACHE_WORD_W-1:0] core_data,
    // memory side
    output logic                      mem_req,
    output mem_bus_pkg::block_addr_t  mem_addr,
    input  logic                      mem_ack,
    input  logic [`ICACHE_BEAT_W-1:0] mem_data
);

    // input side to line store
    logic                      lookup_valid;
    logic [`ICACHE_ADDR_W-1:0] lookup_addr;
    logic                      resp_valid;
    logic [`ICACHE_WORD_W-1:0] resp_data;

    // line store to output side
    logic                      fill_start;
    mem_bus_pkg::block_addr_t  fill_block;
    logic                      beat_valid;
    mem_bus_pkg::beat_idx_t    beat_idx;
    logic [`ICACHE_BEAT_W-1:0] beat_data;

    core_req_port i_core_req_port (
        .clk          (clk),
        .rst          (rst),
        .core_req     (core_req),
        .core_addr    (core_addr),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .core_ack     (core_ack),
        .core_data    (core_data),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr)
    );

    icache_line_store i_icache_line_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .beat_valid   (beat_valid),
        .beat_idx     (beat_idx),
        .beat_data    (beat_data),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .fill_start   (fill_start),
        .fill_block   (fill_block)
    );

    mem_fill_port i_mem_fill_port (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_block (fill_block),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .beat_data  (beat_data)
    );

endmodule

//--- rtl/mem_bus_pkg.sv
`include "icache_config.svh"

package mem_bus_pkg;

    // four-phase master facing memory
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } fill_state_t;

    // beat position inside the line
    typedef logic [$clog2(`ICACHE_BEATS_PER_LINE)-1:0] beat_idx_t;

    // address of one 16-byte block on the memory bus
    typedef logic [`ICACHE_ADDR_W-`ICACHE_BEAT_LSB-1:0] block_addr_t;

endpackage

//--- rtl/mem_fill_port.sv
`include "icache_config.svh"

module mem_fill_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fill_start,
    input  mem_bus_pkg::block_addr_t  fill_block,
    input  logic                      mem_ack,
    input  logic [`ICACHE_BEAT_W-1:0] mem_data,
    output logic                      mem_req,
    output mem_bus_pkg::block_addr_t  mem_addr,
    output logic                      beat_valid,
    output mem_bus_pkg::beat_idx_t    beat_idx,
    output logic [`ICACHE_BEAT_W-1:0] beat_data
);

    mem_bus_pkg::fill_state_t state;

    // first block of the line being fetched
    mem_bus_pkg::block_addr_t base_block;
    mem_bus_pkg::beat_idx_t   beat_cnt;

    logic start_fill;
    logic beat_taken;
    logic last_cnt;

    assign start_fill = (state == mem_bus_pkg::IDLE) && fill_start;
    assign beat_taken = (state == mem_bus_pkg::REQ) && mem_ack;
    assign last_cnt = (beat_cnt == mem_bus_pkg::beat_idx_t'(`ICACHE_BEATS_PER_LINE-1));

    // count only moves while mem_req is low, so the address is stable per beat
    assign mem_addr = base_block + mem_bus_pkg::block_addr_t'(beat_cnt);

    // still the index of the beat just received while beat_valid is high
    assign beat_idx = beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::IDLE;
            beat_cnt <= '0;
            mem_req <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            case (state)
                mem_bus_pkg::IDLE: begin
                    if (fill_start) begin
                        beat_cnt <= '0;
                        mem_req <= 1'b1;
                        state <= mem_bus_pkg::REQ;
                    end
                end
                mem_bus_pkg::REQ: begin
                    // a slow memory just keeps us here
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        beat_valid <= 1'b1;
                        state <= mem_bus_pkg::RELEASE;
                    end
                end
                mem_bus_pkg::RELEASE: begin
                    // wait for ack low before the next beat
                    if (!mem_ack && last_cnt) begin
                        state <= mem_bus_pkg::IDLE;
                    end else if (!mem_ack) begin
                        beat_cnt <= beat_cnt + mem_bus_pkg::beat_idx_t'(1);
                        mem_req <= 1'b1;
                        state <= mem_bus_pkg::REQ;
                    end
                end
                default: begin
                    mem_req <= 1'b0;
                    state <= mem_bus_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            base_block <= fill_block;
        end
    end

    // beat registered as it is acknowledged
    always_ff @(posedge clk) begin
        if (beat_taken) begin
            beat_data <= mem_data;
        end
    end

endmodule

//--- sim/icache_tb.sv
`include "icache_config.svh"

module icache_tb;

    localparam int TIMEOUT = 100;
    localparam int N_RANDOM = 40;
    // first of the four lines used by the random stream
    localparam logic [`ICACHE_ADDR_W-1:0] RANDOM_BASE = 32'h0003_0c00;

    logic                      clk;
    logic                      rst;
    logic                      core_req;
    logic [`ICACHE_ADDR_W-1:0] core_addr;
    logic                      core_ack;
    logic [`ICACHE_WORD_W-1:0] core_data;
    logic                      mem_req;
    mem_bus_pkg::block_addr_t  mem_addr;
    logic                      mem_ack;
    logic [`ICACHE_BEAT_W-1:0] mem_data;
    logic [1:0]                mem_delay;

    logic [31:0] lfsr;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;

    // blocks requested from memory during the current access
    mem_bus_pkg::block_addr_t mem_log[$];
    logic                     mem_req_q;

    // line the cache should hold after the accesses so far
    icache_pkg::tag_t model_tag;
    bit               model_valid;

    logic [`ICACHE_ADDR_W-1:0] random_addr[N_RANDOM];

    icache_top i_icache_top (
        .clk       (clk),
        .rst       (rst),
        .core_req  (core_req),
        .core_addr (core_addr),
        .core_ack  (core_ack),
        .core_data (core_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data)
    );

    tb_main_mem i_tb_main_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .ack_delay (mem_delay),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [`ICACHE_WORD_W-1:0] expected_word(
        input logic [`ICACHE_ADDR_W-1:0] addr
    );
        return {addr[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h3c5a_96e1;
    endfunction

    // new acknowledge delay every cycle
    // memory latches it once per request
    always @(posedge clk) begin : delay_draw
        logic [31:0] bits;
        draw_bits(2, bits);
        mem_delay <= bits[1:0];
    end

    always @(posedge clk) begin
        if (!rst && mem_req && !mem_req_q) begin
            mem_log.push_back(mem_addr);
        end
        mem_req_q <= mem_req;
    end

    function automatic void protocol_error(input string msg);
        $display("protocol violation at %0t: %s", $time, msg);
        errors++;
    endfunction

    // core side four-phase
    assert property (@(posedge clk) disable iff (rst) $rose(core_ack) |-> core_req)
        else protocol_error("core_ack rose while core_req was low");
    assert property (@(posedge clk) disable iff (rst) core_ack && core_req |=> core_ack)
        else protocol_error("core_ack fell before core_req was released");
    assert property (@(posedge clk) disable iff (rst) core_ack && !core_req |=> !core_ack)
        else protocol_error("core_ack not dropped one cycle after core_req fell");
    assert property (@(posedge clk) disable iff (rst)
        core_ack |=> !core_ack || $stable(core_data))
        else protocol_error("core_data changed while core_ack was high");

    // memory side four-phase
    assert property (@(posedge clk) disable iff (rst) $rose(mem_req) |-> !mem_ack)
        else protocol_error("mem_req rose while mem_ack was still high");
    assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req)
        else protocol_error("mem_req dropped before mem_ack");
    assert property (@(posedge clk) disable iff (rst) mem_ack |=> !mem_req)
        else protocol_error("mem_req high after mem_ack was seen");
    assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req || $stable(mem_addr))
        else protocol_error("mem_addr changed during a request");

    task automatic wait_ack(input logic level, input string name, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (core_ack !== level && cycles < TIMEOUT);
        if (core_ack !== level) begin
            $display("%s: core_ack did not reach %b within %0d cycles", name, level, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // one four-phase read, latency counted from the first edge that sees core_req
    task automatic read_word(
        input string name,
        input logic [`ICACHE_ADDR_W-1:0] addr,
        output logic [`ICACHE_WORD_W-1:0] data,
        output int latency
    );
        int cycles;
        core_req <= 1'b1;
        core_addr <= addr;
        wait_ack(1'b1, name, cycles);
        latency = cycles - 1;
        data = core_data;
        core_req <= 1'b0;
        if (!timed_out) begin
            wait_ack(1'b0, name, cycles);
        end
    endtask

    task automatic check_access(
        input string name,
        input logic [`ICACHE_ADDR_W-1:0] addr,
        output int latency
    );
        logic [`ICACHE_WORD_W-1:0] data;
        icache_pkg::tag_t          tag;
        mem_bus_pkg::block_addr_t  first_block;
        int                        exp_reqs;
        latency = 0;
        if (timed_out) return;
        tag = addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
        first_block = {tag, 2'b00};
        exp_reqs = (!model_valid || model_tag != tag) ? 4 : 0;
        mem_log.delete();
        read_word(name, addr, data, latency);
        if (timed_out) return;
        assert (data == expected_word(addr)) else begin
            $display("ERROR %s: data expected %h actual %h", name, expected_word(addr), data);
            errors++;
        end
        assert (mem_log.size() == exp_reqs) else begin
            $display("ERROR %s: mem requests expected %0d actual %0d",
                     name, exp_reqs, mem_log.size());
            errors++;
        end
        for (int i = 0; i < mem_log.size() && i < exp_reqs; i++) begin
            assert (mem_log[i] == first_block + mem_bus_pkg::block_addr_t'(i)) else begin
                $display("ERROR %s: mem_addr %0d expected %h actual %h",
                         name, i, first_block + mem_bus_pkg::block_addr_t'(i), mem_log[i]);
                errors++;
            end
        end
        model_tag = tag;
        model_valid = 1'b1;
    endtask

    task automatic finish_test(input string name, input int start);
        if (errors == start && !timed_out) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", name, errors - start);
        end
    endtask

    initial begin
        logic [31:0] bits;
        int          start;
        int          latency;
        lfsr = 32'h8a97e9b7;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        model_valid = 1'b0;
        model_tag = '0;
        mem_req_q = 1'b0;
        mem_delay = '0;
        rst = 1'b1;
        core_req = 1'b0;
        core_addr = '0;
        // word addresses spread over four lines
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(6, bits);
            random_addr[i] = RANDOM_BASE + {bits[5:0], 2'b00};
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        start = errors;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            assert (!core_ack && !mem_req) else begin
                $display("ERROR reset: core_ack,mem_req expected 00 actual %b%b",
                         core_ack, mem_req);
                errors++;
            end
        end
        finish_test("reset", start);

        start = errors;
        check_access("cold_miss", 32'h0000_1238, latency);
        finish_test("cold_miss", start);

        start = errors;
        check_access("hit", 32'h0000_1204, latency);
        if (!timed_out) begin
            assert (latency == 3) else begin
                $display("ERROR hit: latency expected 3 actual %0d", latency);
                errors++;
            end
        end
        finish_test("hit", start);

        // old line evicted, so coming back to it misses
        start = errors;
        check_access("replace_new", 32'h0000_5a70, latency);
        check_access("replace_old", 32'h0000_1210, latency);
        finish_test("line_replacement", start);

        start = errors;
        for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
            check_access($sformatf("random_%0d", i), random_addr[i], latency);
        end
        finish_test("random_stream", start);

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/tb_main_mem.sv
`include "icache_config.svh"

module tb_main_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_req,
    input  mem_bus_pkg::block_addr_t  mem_addr,
    input  logic [1:0]                ack_delay,
    output logic                      mem_ack,
    output logic [`ICACHE_BEAT_W-1:0] mem_data
);

    localparam logic [`ICACHE_WORD_W-1:0] WORD_KEY = 32'h3c5a_96e1;

    logic       busy;
    logic [1:0] wait_cnt;

    // word at byte address A is A xor the key
    function automatic logic [`ICACHE_BEAT_W-1:0] block_pattern(
        input mem_bus_pkg::block_addr_t blk
    );
        logic [`ICACHE_BEAT_W-1:0] beat;
        logic [`ICACHE_ADDR_W-1:0] byte_addr;
        for (int k = 0; k < `ICACHE_BEAT_W / `ICACHE_WORD_W; k++) begin
            byte_addr = {blk, {`ICACHE_BEAT_LSB{1'b0}}} + 32'(4 * k);
            beat[k*`ICACHE_WORD_W +: `ICACHE_WORD_W] = byte_addr ^ WORD_KEY;
        end
        return beat;
    endfunction

    initial begin
        mem_ack = 1'b0;
        mem_data = '0;
        busy = 1'b0;
        wait_cnt = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            busy <= 1'b0;
        end else if (mem_ack) begin
            // release phase
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req && !busy && ack_delay == 2'd0) begin
            mem_ack <= 1'b1;
            mem_data <= block_pattern(mem_addr);
        end else if (mem_req && !busy) begin
            busy <= 1'b1;
            wait_cnt <= ack_delay - 2'd1;
        end else if (busy && wait_cnt == 2'd0) begin
            busy <= 1'b0;
            mem_ack <= 1'b1;
            mem_data <= block_pattern(mem_addr);
        end else if (busy) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/core_req_port.sv
rtl/icache_line_store.sv
rtl/mem_fill_port.sv
rtl/icache_top.sv
sim/tb_main_mem.sv
sim/icache_tb.sv
